/* verilog/rp_io_pkg.sv */
// Shared widths, sample types and constants for the analog I/O path, referenced by scoped name
`default_nettype none

package rp_io_pkg;

  //////////////////////////////////////////////////
  // Widths and default channel counts
  //////////////////////////////////////////////////

  // Converter and density widths
  parameter int ADC_DW = 16;
  parameter int DAC_DW = 14;
  parameter int PDM_DW = 8;

  // Default counts, overridable from the top level
  parameter int MNO_DEF     = 2;
  parameter int MNG_DEF     = 2;
  parameter int PDM_CHN_DEF = 4;

  //////////////////////////////////////////////////
  // Sample and configuration types
  //////////////////////////////////////////////////

  typedef logic signed [ADC_DW-1:0] adc_sample_t;
  typedef logic signed [DAC_DW-1:0] dac_sample_t;
  // Raw code as seen on the DAC pins
  typedef logic        [DAC_DW-1:0] dac_code_t;
  typedef logic        [PDM_DW-1:0] pdm_cfg_t;
  typedef logic        [1:0]        pdm_addr_t;

  // Modulator range, full scale of a density value
  parameter logic [PDM_DW-1:0] PDM_RNG = 8'd255;

  // DAC mid-scale code, loaded while in reset
  parameter dac_code_t DAC_MID = 14'h1FFF;

endpackage

`default_nettype wire

/* verilog/adc_capture.sv */
// ADC input stage, registers each raw channel and converts it to two's complement for the top level
`default_nettype none
`timescale 1ns/100ps

module adc_capture #(
  // Number of ADC channels
  parameter int MNO = rp_io_pkg::MNO_DEF
) (
  input  wire logic                                adc_clk,
  input  wire logic                                top_rst,
  // Raw converter buses, negative slope
  input  wire rp_io_pkg::adc_sample_t [MNO-1:0]   adc_dat_i,
  // Converted samples, one cycle behind the pins
  output      rp_io_pkg::adc_sample_t [MNO-1:0]   adc_sample_o
);

  //////////////////////////////////////////////////
  // Per channel capture
  //////////////////////////////////////////////////

  for (genvar i = 0; i < MNO; i++) begin : g_adc

    // Conversion result ahead of the register
    rp_io_pkg::adc_sample_t adc_conv;

    // Sign kept, magnitude bits flipped
    // Converter counts down as the input rises
    assign adc_conv = {adc_dat_i[i][rp_io_pkg::ADC_DW-1],
                       ~adc_dat_i[i][rp_io_pkg::ADC_DW-2:0]};

    // Stands in for the IO block input register
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        adc_sample_o[i] <= '0;
      end else begin
        adc_sample_o[i] <= adc_conv;
      end
    end

  end : g_adc

endmodule : adc_capture

`default_nettype wire

/* verilog/dac_output.sv */
// DAC output stage, holds a strobed code per channel in the DAC's inverted-slope format
`default_nettype none
`timescale 1ns/100ps

module dac_output #(
  // Number of DAC channels
  parameter int MNG = rp_io_pkg::MNG_DEF
) (
  input  wire logic                              adc_clk,
  input  wire logic                              top_rst,
  // Signed samples and their load strobe
  input  wire rp_io_pkg::dac_sample_t [MNG-1:0] dac_dat_i,
  input  wire logic                              dac_vld_i,
  // Codes to the DAC pins
  output      rp_io_pkg::dac_code_t   [MNG-1:0] dac_code_o,
  // Registered reset to the converter
  output      logic                              dac_rst_o
);

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  for (genvar i = 0; i < MNG; i++) begin : g_dac

    rp_io_pkg::dac_code_t dac_conv;

    // Signed to offset code with the slope inverted
    // Same sign-keep rule as the ADC side
    assign dac_conv = {dac_dat_i[i][rp_io_pkg::DAC_DW-1],
                       ~dac_dat_i[i][rp_io_pkg::DAC_DW-2:0]};

    // Mid-scale in reset, new code only on strobe
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        dac_code_o[i] <= rp_io_pkg::DAC_MID;
      end else if (dac_vld_i) begin
        dac_code_o[i] <= dac_conv;
      end
    end

  end : g_dac

  //////////////////////////////////////////////////
  // DAC reset
  //////////////////////////////////////////////////

  // Drops on the first edge after release
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_rst_o <= 1'b1;
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

  // Codes only move on a strobed cycle
  a_dac_hold : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !dac_vld_i |=> $stable(dac_code_o)
  ) else $error("dac_code_o changed without dac_vld_i");

endmodule : dac_output

`default_nettype wire

/* verilog/pdm_regs.sv */
// Density register block for the PDM outputs, written and read back by address from the top level
`default_nettype none
`timescale 1ns/100ps

module pdm_regs #(
  // Number of PDM channels
  parameter int unsigned PDM_CHN = rp_io_pkg::PDM_CHN_DEF
) (
  input  wire logic                                  adc_clk,
  input  wire logic                                  top_rst,
  // Write strobe, one cycle per write
  input  wire logic                                  cfg_we_i,
  input  wire rp_io_pkg::pdm_addr_t                  cfg_addr_i,
  input  wire rp_io_pkg::pdm_cfg_t                   cfg_wdata_i,
  // Registered readback
  output      rp_io_pkg::pdm_cfg_t                   cfg_rdata_o,
  // Density values to the modulator
  output      rp_io_pkg::pdm_cfg_t  [PDM_CHN-1:0]    pdm_cfg
);

  // Address hits an existing channel
  logic addr_ok;

  assign addr_ok = 32'(cfg_addr_i) < PDM_CHN;

  //////////////////////////////////////////////////
  // Register array
  //////////////////////////////////////////////////

  // Stray addresses are dropped
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      pdm_cfg <= '0;
    end else if (cfg_we_i && addr_ok) begin
      pdm_cfg[cfg_addr_i] <= cfg_wdata_i;
    end
  end

  // Readback, old value on a same-cycle write
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cfg_rdata_o <= '0;
    end else if (addr_ok) begin
      cfg_rdata_o <= pdm_cfg[cfg_addr_i];
    end else begin
      cfg_rdata_o <= '0;
    end
  end

  // Bus master must stay inside the channel map
  a_cfg_addr : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    cfg_we_i |-> addr_ok
  ) else $error("PDM register write to address %0h out of range", cfg_addr_i);

endmodule : pdm_regs

`default_nettype wire

/* verilog/pdm.sv */
// First-order pulse-density modulator, turns each density value into a 1-bit stream for the top level
`default_nettype none
`timescale 1ns/100ps

module pdm #(
  // Number of PDM channels
  parameter int unsigned PDM_CHN = rp_io_pkg::PDM_CHN_DEF
) (
  input  wire logic                                adc_clk,
  input  wire logic                                top_rst,
  // Density per channel, used as it stands each cycle
  input  wire rp_io_pkg::pdm_cfg_t  [PDM_CHN-1:0]  pdm_cfg,
  // One stream bit per channel
  output      logic                 [PDM_CHN-1:0]  pdm_o
);

  // Accumulator width, one spare bit for the carry
  localparam int AW = rp_io_pkg::PDM_DW + 1;

  // Range extended to accumulator width
  localparam logic [AW-1:0] RNG_W = {1'b0, rp_io_pkg::PDM_RNG};

  //////////////////////////////////////////////////
  // Per channel modulator
  //////////////////////////////////////////////////

  for (genvar i = 0; i < PDM_CHN; i++) begin : g_pdm

    logic [AW-1:0] acc;
    logic [AW-1:0] acc_sum;
    logic          acc_ovr;

    // Running error plus this cycle's density
    assign acc_sum = acc + {1'b0, pdm_cfg[i]};
    // Full range crossed, time for a one
    assign acc_ovr = acc_sum >= RNG_W;

    // Remainder carried so ones spread evenly
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        acc     <= '0;
        pdm_o[i] <= 1'b0;
      end else if (acc_ovr) begin
        acc     <= acc_sum - RNG_W;
        pdm_o[i] <= 1'b1;
      end else begin
        acc     <= acc_sum;
        pdm_o[i] <= 1'b0;
      end
    end

    // Keeps the ones count per window exact
    a_acc_rng : assert property (
      @(posedge adc_clk) disable iff (top_rst)
      acc < RNG_W
    ) else $error("PDM accumulator %0d out of range: %0h", i, acc);

  end : g_pdm

endmodule : pdm

`default_nettype wire

/* verilog/rp_io_top.sv */
// Board top level of the analog I/O path, wiring ADC capture, DAC output and PDM outputs to the pins
`default_nettype none
`timescale 1ns/100ps

module rp_io_top #(
  // Channel counts passed to the blocks below
  parameter int          MNO     = rp_io_pkg::MNO_DEF,
  parameter int          MNG     = rp_io_pkg::MNG_DEF,
  parameter int unsigned PDM_CHN = rp_io_pkg::PDM_CHN_DEF
) (
  input  wire logic                                  adc_clk,
  input  wire logic                                  top_rst,
  // ADC
  input  wire rp_io_pkg::adc_sample_t [MNO-1:0]     adc_dat_i,
  output      rp_io_pkg::adc_sample_t [MNO-1:0]     adc_sample_o,
  // DAC, one parallel bus per channel
  input  wire rp_io_pkg::dac_sample_t [MNG-1:0]     dac_dat_i,
  input  wire logic                                  dac_vld_i,
  output      rp_io_pkg::dac_code_t   [MNG-1:0]     dac_code_o,
  output      logic                                  dac_rst_o,
  // PDM configuration port
  input  wire logic                                  cfg_we_i,
  input  wire rp_io_pkg::pdm_addr_t                  cfg_addr_i,
  input  wire rp_io_pkg::pdm_cfg_t                   cfg_wdata_i,
  output      rp_io_pkg::pdm_cfg_t                   cfg_rdata_o,
  // Low-speed analog outputs
  output      logic                   [PDM_CHN-1:0] pdm_o
);

  //////////////////////////////////////////////////
  // ADC
  //////////////////////////////////////////////////

  // Samples leave the top unchanged
  adc_capture #(
    .MNO (MNO)
  ) adc_capture_i (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .adc_dat_i    (adc_dat_i),
    .adc_sample_o (adc_sample_o)
  );

  //////////////////////////////////////////////////
  // DAC
  //////////////////////////////////////////////////

  // Channels stay on separate buses, no interleave
  dac_output #(
    .MNG (MNG)
  ) dac_output_i (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .dac_dat_i  (dac_dat_i),
    .dac_vld_i  (dac_vld_i),
    .dac_code_o (dac_code_o),
    .dac_rst_o  (dac_rst_o)
  );

  //////////////////////////////////////////////////
  // PDM
  //////////////////////////////////////////////////

  // Density values from registers to modulator
  rp_io_pkg::pdm_cfg_t [PDM_CHN-1:0] pdm_cfg;

  pdm_regs #(
    .PDM_CHN (PDM_CHN)
  ) pdm_regs_i (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .pdm_cfg     (pdm_cfg)
  );

  // Fixed range of 255, always enabled
  pdm #(
    .PDM_CHN (PDM_CHN)
  ) pdm_i (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .pdm_cfg (pdm_cfg),
    .pdm_o   (pdm_o)
  );

endmodule : rp_io_top

`default_nettype wire

/* dv/rp_io_tb.sv */
// Self-checking testbench for the analog I/O top level, run from the project root with the vectors file
`default_nettype none
`timescale 1ns/100ps

module rp_io_tb;

  localparam int MNO     = rp_io_pkg::MNO_DEF;
  localparam int MNG     = rp_io_pkg::MNG_DEF;
  localparam int PDM_CHN = rp_io_pkg::PDM_CHN_DEF;
  localparam int N_RAND  = 64;
  // DAC mid-scale, held through reset
  localparam rp_io_pkg::dac_code_t MID_CODE = 14'h1FFF;

  logic                                 adc_clk;
  logic                                 top_rst;
  rp_io_pkg::adc_sample_t [MNO-1:0]     adc_dat_i;
  rp_io_pkg::adc_sample_t [MNO-1:0]     adc_sample_o;
  rp_io_pkg::dac_sample_t [MNG-1:0]     dac_dat_i;
  logic                                 dac_vld_i;
  rp_io_pkg::dac_code_t   [MNG-1:0]     dac_code_o;
  logic                                 dac_rst_o;
  logic                                 cfg_we_i;
  rp_io_pkg::pdm_addr_t                 cfg_addr_i;
  rp_io_pkg::pdm_cfg_t                  cfg_wdata_i;
  rp_io_pkg::pdm_cfg_t                  cfg_rdata_o;
  logic                   [PDM_CHN-1:0] pdm_o;

  // Vector store, one entry per data line
  string       kind_q [$];
  logic [31:0] chn_q [$];
  logic [31:0] opd_q [$];
  logic [31:0] res_q [$];
  logic        vec_ready = 1'b0;

  integer seed      = 32'he1393801;
  int     n_pass    = 0;
  int     n_fail    = 0;
  int     test_errs = 0;
  // Last code loaded per DAC channel
  rp_io_pkg::dac_code_t dac_model [MNG];

  rp_io_top #(
    .MNO     (MNO),
    .MNG     (MNG),
    .PDM_CHN (PDM_CHN)
  ) rp_io_top_i (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .adc_dat_i    (adc_dat_i),
    .adc_sample_o (adc_sample_o),
    .dac_dat_i    (dac_dat_i),
    .dac_vld_i    (dac_vld_i),
    .dac_code_o   (dac_code_o),
    .dac_rst_o    (dac_rst_o),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_rdata_o  (cfg_rdata_o),
    .pdm_o        (pdm_o)
  );

  // 20 ns period
  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////
  // Expected values and compares
  //////////////////////////////////////////////////

  // Sign stays, all magnitude bits flip
  function automatic rp_io_pkg::adc_sample_t adc_expect(input rp_io_pkg::adc_sample_t raw);
    return raw ^ {1'b0, {(rp_io_pkg::ADC_DW-1){1'b1}}};
  endfunction

  function automatic rp_io_pkg::dac_code_t dac_expect(input rp_io_pkg::dac_sample_t smp);
    return smp ^ {1'b0, {(rp_io_pkg::DAC_DW-1){1'b1}}};
  endfunction

  task automatic compare_adc(input string name, input rp_io_pkg::adc_sample_t got,
                             input rp_io_pkg::adc_sample_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic compare_dac(input string name, input rp_io_pkg::dac_code_t got,
                             input rp_io_pkg::dac_code_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic compare_cfg(input string name, input rp_io_pkg::pdm_cfg_t got,
                             input rp_io_pkg::pdm_cfg_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  // Single flags such as dac_rst_o or one pdm_o bit
  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  // One summary line per test
  task automatic close_test(input string name);
    if (test_errs == 0) begin
      n_pass++;
      $display("ok    %s", name);
    end else begin
      n_fail++;
      $display("bad   %s, %0d mismatches", name, test_errs);
    end
    test_errs = 0;
  endtask

  //////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////

  // Lines starting with # are skipped
  task automatic load_vectors();
    int          fd;
    string       line;
    string       kind;
    logic [31:0] chn;
    logic [31:0] opd;
    logic [31:0] res;
    fd = $fopen("dv/rp_io_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open dv/rp_io_vectors.txt, no directed vectors run");
      n_fail++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.substr(0, 0) != "#" &&
            $sscanf(line, "%s %h %h %h", kind, chn, opd, res) == 4) begin
          kind_q.push_back(kind);
          chn_q.push_back(chn);
          opd_q.push_back(opd);
          res_q.push_back(res);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic reset_outputs_check(input logic rst_exp);
    compare_bit("dac_rst_o", dac_rst_o, rst_exp);
    compare_cfg("cfg_rdata_o", cfg_rdata_o, '0);
    for (int ch = 0; ch < MNG; ch++) begin
      compare_dac($sformatf("dac_code_o[%0d]", ch), dac_code_o[ch], MID_CODE);
    end
    for (int ch = 0; ch < PDM_CHN; ch++) begin
      compare_bit($sformatf("pdm_o[%0d]", ch), pdm_o[ch], 1'b0);
    end
  endtask

  task automatic dac_model_check();
    for (int ch = 0; ch < MNG; ch++) begin
      compare_dac($sformatf("dac_code_o[%0d]", ch), dac_code_o[ch], dac_model[ch]);
    end
  endtask

  // Raw code on one channel, others idle at zero
  task automatic drive_adc_vector(input int ch, input rp_io_pkg::adc_sample_t raw,
                                  input rp_io_pkg::adc_sample_t res);
    @(posedge adc_clk);
    adc_dat_i     <= '0;
    adc_dat_i[ch] <= raw;
    @(posedge adc_clk);
    @(negedge adc_clk);
    compare_adc($sformatf("adc_sample_o[%0d]", ch), adc_sample_o[ch], res);
  endtask

  // File sample on one channel, random on the rest, single strobe
  task automatic strobe_dac_vector(input int ch, input rp_io_pkg::dac_sample_t smp,
                                   input rp_io_pkg::dac_code_t res);
    rp_io_pkg::dac_sample_t other;
    @(posedge adc_clk);
    for (int k = 0; k < MNG; k++) begin
      other = rp_io_pkg::dac_sample_t'($random(seed));
      if (k == ch) begin
        dac_dat_i[k] <= smp;
        dac_model[k] = res;
      end else begin
        dac_dat_i[k] <= other;
        dac_model[k] = dac_expect(other);
      end
    end
    dac_vld_i <= 1'b1;
    @(posedge adc_clk);
    dac_vld_i <= 1'b0;
    @(negedge adc_clk);
    dac_model_check();
  endtask

  // Write all channels, read each back, then count ones
  task automatic pdm_density_batch(input int first);
    int cnt  [PDM_CHN];
    int want [PDM_CHN];
    int ch;
    for (int k = 0; k < PDM_CHN; k++) begin
      ch        = int'(chn_q[first+k]);
      want[ch]  = int'(res_q[first+k]);
      cnt[k]    = 0;
      @(posedge adc_clk);
      cfg_we_i    <= 1'b1;
      cfg_addr_i  <= rp_io_pkg::pdm_addr_t'(chn_q[first+k]);
      cfg_wdata_i <= rp_io_pkg::pdm_cfg_t'(opd_q[first+k]);
    end
    @(posedge adc_clk);
    cfg_we_i <= 1'b0;
    // Readback lags the address by one edge
    for (int k = 0; k < PDM_CHN; k++) begin
      @(posedge adc_clk);
      cfg_addr_i <= rp_io_pkg::pdm_addr_t'(chn_q[first+k]);
      @(posedge adc_clk);
      @(negedge adc_clk);
      compare_cfg($sformatf("cfg_rdata_o at %0h", chn_q[first+k]), cfg_rdata_o,
                  rp_io_pkg::pdm_cfg_t'(opd_q[first+k]));
    end
    // Any 255-cycle window holds exactly the density in ones
    repeat (255) begin
      @(posedge adc_clk);
      @(negedge adc_clk);
      for (int k = 0; k < PDM_CHN; k++) begin
        if (pdm_o[k]) cnt[k]++;
      end
    end
    for (int k = 0; k < PDM_CHN; k++) begin
      compare_count($sformatf("pdm_o[%0d] ones", k), cnt[k], want[k]);
    end
  endtask

  // New ADC and DAC samples every other cycle, strobe kept high
  task automatic random_traffic();
    rp_io_pkg::adc_sample_t adc_raw [MNO];
    rp_io_pkg::dac_sample_t dac_raw;
    repeat (N_RAND) begin
      @(posedge adc_clk);
      for (int k = 0; k < MNO; k++) begin
        adc_raw[k] = rp_io_pkg::adc_sample_t'($random(seed));
        adc_dat_i[k] <= adc_raw[k];
      end
      for (int k = 0; k < MNG; k++) begin
        dac_raw = rp_io_pkg::dac_sample_t'($random(seed));
        dac_dat_i[k] <= dac_raw;
        dac_model[k] = dac_expect(dac_raw);
      end
      dac_vld_i <= 1'b1;
      @(posedge adc_clk);
      @(negedge adc_clk);
      for (int k = 0; k < MNO; k++) begin
        compare_adc($sformatf("adc_sample_o[%0d]", k), adc_sample_o[k],
                    adc_expect(adc_raw[k]));
      end
      dac_model_check();
    end
  endtask

  // Inputs keep moving, codes must not
  task automatic dac_hold_check();
    repeat (6) begin
      @(posedge adc_clk);
      dac_vld_i <= 1'b0;
      for (int k = 0; k < MNG; k++) begin
        dac_dat_i[k] <= rp_io_pkg::dac_sample_t'($random(seed));
      end
      @(negedge adc_clk);
      dac_model_check();
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin : main
    int idx;
    top_rst     = 1'b1;
    adc_dat_i   = '0;
    dac_dat_i   = '0;
    dac_vld_i   = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    load_vectors();
    vec_ready = 1'b1;
    for (int k = 0; k < MNG; k++) begin
      dac_model[k] = MID_CODE;
    end
    // Three cycles in reset, DAC reset drops one edge after release
    repeat (2) begin
      @(posedge adc_clk);
      @(negedge adc_clk);
      reset_outputs_check(1'b1);
    end
    @(posedge adc_clk);
    top_rst <= 1'b0;
    @(negedge adc_clk);
    reset_outputs_check(1'b1);
    @(posedge adc_clk);
    @(negedge adc_clk);
    reset_outputs_check(1'b0);
    close_test("reset state");
    idx = 0;
    while (idx < kind_q.size()) begin
      if (kind_q[idx] == "A") begin
        drive_adc_vector(int'(chn_q[idx]), rp_io_pkg::adc_sample_t'(opd_q[idx]),
                         rp_io_pkg::adc_sample_t'(res_q[idx]));
        close_test($sformatf("vector %0d ADC", idx));
        idx++;
      end else if (kind_q[idx] == "D") begin
        strobe_dac_vector(int'(chn_q[idx]), rp_io_pkg::dac_sample_t'(opd_q[idx]),
                          rp_io_pkg::dac_code_t'(res_q[idx]));
        close_test($sformatf("vector %0d DAC", idx));
        idx++;
      end else if (kind_q[idx] == "P" && idx + PDM_CHN <= kind_q.size()) begin
        pdm_density_batch(idx);
        close_test($sformatf("vectors %0d..%0d PDM", idx, idx + PDM_CHN - 1));
        idx += PDM_CHN;
      end else begin
        $display("Vector %0d has an unknown kind or an incomplete PDM group", idx);
        test_errs++;
        close_test($sformatf("vector %0d", idx));
        idx++;
      end
    end
    random_traffic();
    close_test("random ADC and DAC traffic");
    dac_hold_check();
    close_test("DAC hold without strobe");
    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Budget scales with the number of file lines
  initial begin : watchdog
    int limit;
    wait (vec_ready);
    limit = kind_q.size() * 300 + 2000;
    repeat (limit) @(posedge adc_clk);
    $display("Run timed out, no result after %0d clock cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : rp_io_tb

`default_nettype wire

/* dv/rp_io_vectors.txt */
# kind channel operand expected, all hex; A: raw ADC code -> adc_sample_o, D: signed sample -> dac_code_o
# P: density written to channel -> ones in 255 cycles; P lines come in groups of one line per channel
A 0 0000 7fff
A 1 7fff 0000
A 0 8000 ffff
A 1 ffff 8000
A 0 1234 6dcb
A 1 a5a5 da5a
D 0 0000 1fff
D 1 1fff 0000
D 0 2000 3fff
D 1 3fff 2000
D 0 0abc 1543
D 1 2a5a 35a5
P 0 00 00
P 1 ff ff
P 2 01 01
P 3 80 80
P 0 55 55
P 1 aa aa
P 2 fe fe
P 3 07 07

/* rp_io_top.f */
verilog/rp_io_pkg.sv
verilog/adc_capture.sv
verilog/dac_output.sv
verilog/pdm_regs.sv
verilog/pdm.sv
verilog/rp_io_top.sv
dv/rp_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the analog I/O testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module rp_io_tb -f rp_io_top.f

./obj_dir/Vrp_io_tb 2>&1 | tee sim.log

# Result comes from the log, the binary exits cleanly either way
if grep -q "SIMULATION FAILED" sim.log; then
  echo "run_sim: testbench reported failure"
  exit 1
fi

# No verdict at all means the run died early
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "run_sim: no verdict found in sim.log"
  exit 1
fi

echo "run_sim: done"
